//--- design/core_pkg.sv
// Core package with shared widths, opcode constants and the structs passed between stages
package core_pkg;

    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  arch_reg_t;
    typedef logic [5:0]  phys_reg_t;
    typedef logic [3:0]  rob_idx_t;
    typedef logic [1:0]  alu_op_t;

    // Counts follow the index widths
    localparam int ARCH_REGS   = 2 ** $bits(arch_reg_t);
    localparam int PHYS_REGS   = 2 ** $bits(phys_reg_t);
    localparam int ROB_ENTRIES = 2 ** $bits(rob_idx_t);

    localparam logic [6:0] OPCODE_ARITH_I = 7'b0010011;
    localparam logic [6:0] OPCODE_ARITH_R = 7'b0110011;
    localparam logic [6:0] FUNCT7_SUB     = 7'b0100000;

    localparam alu_op_t ALU_ADD  = 2'd0;
    localparam alu_op_t ALU_SUB  = 2'd1;
    localparam alu_op_t ALU_NONE = 2'd3;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_pkt_t;

    // Renamed operation, imm is zero for register forms
    typedef struct packed {
        logic      valid;
        rob_idx_t  rob_idx;
        alu_op_t   alu_op;
        phys_reg_t phys_rd;
        phys_reg_t phys_rs1;
        phys_reg_t phys_rs2;
        logic      uses_rs2;
        data_t     imm;
    } uop_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        arch_reg_t arch_rd;
        phys_reg_t phys_rd;
        phys_reg_t old_phys_rd;
    } rob_alloc_t;

    typedef struct packed {
        logic      valid;
        rob_idx_t  rob_idx;
        phys_reg_t phys_rd;
        data_t     value;
    } wb_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t phys;
    } free_ret_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        arch_reg_t arch_rd;
        data_t     value;
    } commit_t;

endpackage

//--- design/fetch_stage.sv
// Fetch stage with PC counter and circular instruction buffer fed from instruction memory
`timescale 1ns/1ps

module fetch_stage #(
    parameter int FETCH_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  core_pkg::inst_t      imem_data,
    input  logic                 imem_ready,
    input  logic                 fetch_pop,
    output core_pkg::addr_t      imem_addr,
    output logic                 imem_req,
    output logic                 fetch_valid,
    output core_pkg::fetch_pkt_t fetch_pkt
);

    localparam int PTR_W = $clog2(FETCH_DEPTH);

    core_pkg::addr_t      pc;
    core_pkg::fetch_pkt_t buffer [FETCH_DEPTH];
    // Extra top bit tells full from empty
    logic [PTR_W:0]       head;
    logic [PTR_W:0]       tail;
    logic                 full;
    logic                 transfer;

    assign full = (head[PTR_W] != tail[PTR_W]) &&
                  (head[PTR_W-1:0] == tail[PTR_W-1:0]);

    assign imem_req    = !full;
    assign imem_addr   = pc;
    assign transfer    = imem_req && imem_ready;
    assign fetch_valid = head != tail;
    assign fetch_pkt   = buffer[head[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc   <= '0;
            head <= '0;
            tail <= '0;
        end else begin
            // PC only moves on an accepted word
            if (transfer) begin
                pc   <= pc + 32'd4;
                tail <= tail + 1'b1;
            end
            if (fetch_pop) begin
                head <= head + 1'b1;
            end
        end
    end

    // Each entry keeps the PC it was fetched from
    always_ff @(posedge clk) begin
        if (transfer) begin
            buffer[tail[PTR_W-1:0]] <= '{pc: pc, inst: imem_data};
        end
    end

    a_pop_when_valid: assert property (@(posedge clk) disable iff (reset)
        fetch_pop |-> fetch_valid)
        else $error("Rename popped an empty instruction buffer");

endmodule

//--- design/rename_stage.sv
// Rename stage decoding instructions, mapping registers and allocating reorder buffer slots
`timescale 1ns/1ps

module rename_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fetch_valid,
    input  core_pkg::fetch_pkt_t fetch_pkt,
    input  logic                 rob_full,
    input  core_pkg::rob_idx_t   alloc_idx,
    input  logic                 iq_full,
    input  core_pkg::free_ret_t  free_ret,
    output logic                 fetch_pop,
    output core_pkg::rob_alloc_t rob_alloc,
    output core_pkg::uop_t       uop
);

    localparam int FL_DEPTH = core_pkg::PHYS_REGS - core_pkg::ARCH_REGS;
    localparam int FL_PTR_W = $clog2(FL_DEPTH);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    core_pkg::arch_reg_t rd;
    core_pkg::arch_reg_t rs1;
    core_pkg::arch_reg_t rs2;
    core_pkg::arch_reg_t dest_rd;
    core_pkg::data_t     imm;
    core_pkg::alu_op_t   alu_op;
    logic                uses_rs2;
    logic                writes_rd;
    logic                take;
    logic                fl_pop;
    logic                fl_empty;
    core_pkg::phys_reg_t new_phys;

    core_pkg::phys_reg_t map_table [core_pkg::ARCH_REGS];
    core_pkg::phys_reg_t free_list [FL_DEPTH];
    logic [FL_PTR_W:0]   fl_head;
    logic [FL_PTR_W:0]   fl_tail;

    assign opcode = fetch_pkt.inst[6:0];
    assign rd     = fetch_pkt.inst[11:7];
    assign funct3 = fetch_pkt.inst[14:12];
    assign rs1    = fetch_pkt.inst[19:15];
    assign rs2    = fetch_pkt.inst[24:20];
    assign funct7 = fetch_pkt.inst[31:25];

    // Only ADDI, ADD and SUB produce a result
    always_comb begin
        alu_op = core_pkg::ALU_NONE;
        if (funct3 == 3'b000) begin
            if (opcode == core_pkg::OPCODE_ARITH_I) begin
                alu_op = core_pkg::ALU_ADD;
            end else if (opcode == core_pkg::OPCODE_ARITH_R && funct7 == 7'b0) begin
                alu_op = core_pkg::ALU_ADD;
            end else if (opcode == core_pkg::OPCODE_ARITH_R &&
                         funct7 == core_pkg::FUNCT7_SUB) begin
                alu_op = core_pkg::ALU_SUB;
            end
        end
    end

    assign uses_rs2  = (opcode == core_pkg::OPCODE_ARITH_R) && (alu_op != core_pkg::ALU_NONE);
    assign imm       = (opcode == core_pkg::OPCODE_ARITH_I) ?
                       {{20{fetch_pkt.inst[31]}}, fetch_pkt.inst[31:20]} : '0;
    assign dest_rd   = (alu_op != core_pkg::ALU_NONE) ? rd : '0;
    assign writes_rd = dest_rd != '0;

    assign fl_empty  = fl_head == fl_tail;
    assign new_phys  = free_list[fl_head[FL_PTR_W-1:0]];
    // A free register is needed only for a real destination
    assign take      = fetch_valid && !rob_full && !iq_full && !(writes_rd && fl_empty);
    assign fl_pop    = take && writes_rd;
    assign fetch_pop = take;

    always_comb begin
        rob_alloc.valid       = take;
        rob_alloc.pc          = fetch_pkt.pc;
        rob_alloc.arch_rd     = dest_rd;
        rob_alloc.phys_rd     = writes_rd ? new_phys : '0;
        rob_alloc.old_phys_rd = map_table[dest_rd];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // Identity map, spare registers all free
            for (int i = 0; i < core_pkg::ARCH_REGS; i++) begin
                map_table[i] <= core_pkg::phys_reg_t'(i);
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                free_list[i] <= core_pkg::phys_reg_t'(core_pkg::ARCH_REGS + i);
            end
            fl_head <= '0;
            fl_tail <= {1'b1, {FL_PTR_W{1'b0}}};
        end else begin
            if (fl_pop) begin
                map_table[dest_rd] <= new_phys;
                fl_head            <= fl_head + 1'b1;
            end
            if (free_ret.valid) begin
                free_list[fl_tail[FL_PTR_W-1:0]] <= free_ret.phys;
                fl_tail                          <= fl_tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            uop.valid <= 1'b0;
        end else begin
            uop.valid    <= take;
            uop.rob_idx  <= alloc_idx;
            uop.alu_op   <= alu_op;
            uop.phys_rd  <= writes_rd ? new_phys : '0;
            uop.phys_rs1 <= map_table[rs1];
            uop.phys_rs2 <= uses_rs2 ? map_table[rs2] : '0;
            uop.uses_rs2 <= uses_rs2;
            uop.imm      <= imm;
        end
    end

    // A returned register is always one the list gave out, so the list has room
    a_no_return_full: assert property (@(posedge clk) disable iff (reset)
        free_ret.valid |-> !((fl_head[FL_PTR_W] != fl_tail[FL_PTR_W]) &&
                             (fl_head[FL_PTR_W-1:0] == fl_tail[FL_PTR_W-1:0])))
        else $error("Register returned to a full free list");

endmodule

//--- design/issue_stage.sv
// Issue stage with in-order queue, physical register file, ALU and writeback register
`timescale 1ns/1ps

module issue_stage #(
    parameter int IQ_DEPTH = 8
) (
    input  logic           clk,
    input  logic           reset,
    input  core_pkg::uop_t uop,
    output logic           iq_full,
    output core_pkg::wb_t  wb
);

    localparam int PTR_W = $clog2(IQ_DEPTH);
    localparam int OCC_W = PTR_W + 2;
    localparam logic [core_pkg::PHYS_REGS-1:0] READY_INIT =
        {{(core_pkg::PHYS_REGS - core_pkg::ARCH_REGS){1'b0}}, {core_pkg::ARCH_REGS{1'b1}}};

    core_pkg::uop_t  queue [IQ_DEPTH];
    logic [PTR_W:0]  head;
    logic [PTR_W:0]  tail;
    logic [PTR_W:0]  count;
    logic [OCC_W-1:0] occupancy;
    core_pkg::data_t regfile [core_pkg::PHYS_REGS];
    logic [core_pkg::PHYS_REGS-1:0] ready;
    core_pkg::uop_t  hd;
    logic            empty;
    logic            rs1_ready;
    logic            rs2_ready;
    logic            issue;
    core_pkg::data_t op_a;
    core_pkg::data_t op_b;
    core_pkg::data_t alu_result;

    // Count the uop already on its way from rename
    assign count     = tail - head;
    assign occupancy = {1'b0, count} + OCC_W'(uop.valid);
    assign iq_full   = occupancy >= OCC_W'(IQ_DEPTH);

    assign empty     = head == tail;
    assign hd        = queue[head[PTR_W-1:0]];
    assign rs1_ready = ready[hd.phys_rs1];
    assign rs2_ready = !hd.uses_rs2 || ready[hd.phys_rs2];
    assign issue     = !empty && rs1_ready && rs2_ready;

    assign op_a = regfile[hd.phys_rs1];
    assign op_b = hd.uses_rs2 ? regfile[hd.phys_rs2] : hd.imm;

    always_comb begin
        case (hd.alu_op)
            core_pkg::ALU_ADD: alu_result = op_a + op_b;
            core_pkg::ALU_SUB: alu_result = op_a - op_b;
            default:           alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head     <= '0;
            tail     <= '0;
            ready    <= READY_INIT;
            wb.valid <= 1'b0;
            // Architectural state starts at zero
            for (int i = 0; i < core_pkg::ARCH_REGS; i++) begin
                regfile[i] <= '0;
            end
        end else begin
            if (uop.valid) begin
                queue[tail[PTR_W-1:0]] <= uop;
                tail                   <= tail + 1'b1;
                if (uop.phys_rd != '0) begin
                    ready[uop.phys_rd] <= 1'b0;
                end
            end
            if (issue) begin
                head <= head + 1'b1;
            end
            wb.valid   <= issue;
            wb.rob_idx <= hd.rob_idx;
            wb.phys_rd <= hd.phys_rd;
            // No destination means nothing to report
            wb.value   <= (hd.phys_rd != '0) ? alu_result : '0;
            // Register 0 is never written so it stays zero and ready
            if (wb.valid && wb.phys_rd != '0) begin
                regfile[wb.phys_rd] <= wb.value;
                ready[wb.phys_rd]   <= 1'b1;
            end
        end
    end

    // A result still in the writeback register is not yet readable
    a_sources_ready: assert property (@(posedge clk) disable iff (reset)
        issue && wb.valid && wb.phys_rd != '0 |->
            wb.phys_rd != hd.phys_rs1 && !(hd.uses_rs2 && wb.phys_rd == hd.phys_rs2))
        else $error("Issued with a source still in writeback");

endmodule

//--- design/reorder_buffer.sv
// Reorder buffer tracking completion and retiring operations in program order
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                 clk,
    input  logic                 reset,
    input  core_pkg::rob_alloc_t rob_alloc,
    input  core_pkg::wb_t        wb,
    output logic                 rob_full,
    output core_pkg::rob_idx_t   alloc_idx,
    output core_pkg::free_ret_t  free_ret,
    output core_pkg::commit_t    commit
);

    localparam int PTR_W = $bits(core_pkg::rob_idx_t);

    typedef struct packed {
        core_pkg::addr_t     pc;
        core_pkg::arch_reg_t arch_rd;
        core_pkg::phys_reg_t phys_rd;
        core_pkg::phys_reg_t old_phys_rd;
        core_pkg::data_t     value;
    } rob_entry_t;

    rob_entry_t                       entries [core_pkg::ROB_ENTRIES];
    logic [core_pkg::ROB_ENTRIES-1:0] done;
    logic [PTR_W:0]                   head;
    logic [PTR_W:0]                   tail;
    core_pkg::rob_idx_t               head_idx;
    logic                             empty;
    logic                             retire;

    assign head_idx  = head[PTR_W-1:0];
    assign alloc_idx = tail[PTR_W-1:0];
    assign empty     = head == tail;
    assign rob_full  = (head[PTR_W] != tail[PTR_W]) && (head_idx == alloc_idx);
    assign retire    = !empty && done[head_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            head           <= '0;
            tail           <= '0;
            done           <= '0;
            free_ret.valid <= 1'b0;
            commit.valid   <= 1'b0;
        end else begin
            if (rob_alloc.valid) begin
                entries[alloc_idx].pc          <= rob_alloc.pc;
                entries[alloc_idx].arch_rd     <= rob_alloc.arch_rd;
                entries[alloc_idx].phys_rd     <= rob_alloc.phys_rd;
                entries[alloc_idx].old_phys_rd <= rob_alloc.old_phys_rd;
                done[alloc_idx]                <= 1'b0;
                tail                           <= tail + 1'b1;
            end
            // Completion comes back by slot index
            if (wb.valid) begin
                entries[wb.rob_idx].value <= wb.value;
                done[wb.rob_idx]          <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            // x0 was never renamed, nothing to give back
            free_ret.valid <= retire && (entries[head_idx].arch_rd != '0);
            free_ret.phys  <= entries[head_idx].old_phys_rd;
            commit.valid   <= retire;
            commit.pc      <= entries[head_idx].pc;
            commit.arch_rd <= entries[head_idx].arch_rd;
            commit.value   <= entries[head_idx].value;
        end
    end

    a_no_alloc_full: assert property (@(posedge clk) disable iff (reset)
        rob_alloc.valid |-> !rob_full)
        else $error("Reorder buffer allocated while full");

    // Writeback must land on the slot that owns its destination
    a_wb_slot_match: assert property (@(posedge clk) disable iff (reset)
        wb.valid |-> wb.phys_rd == entries[wb.rob_idx].phys_rd)
        else $error("Writeback slot does not match its destination");

endmodule

//--- design/rename_core.sv
// Core top level connecting fetch, rename, issue and reorder buffer stages
`timescale 1ns/1ps

module rename_core #(
    parameter int FETCH_DEPTH = 8,
    parameter int IQ_DEPTH    = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  core_pkg::inst_t   imem_data,
    input  logic              imem_ready,
    output core_pkg::addr_t   imem_addr,
    output logic              imem_req,
    output core_pkg::commit_t commit
);

    logic                 fetch_valid;
    logic                 fetch_pop;
    core_pkg::fetch_pkt_t fetch_pkt;
    logic                 rob_full;
    logic                 iq_full;
    core_pkg::rob_idx_t   alloc_idx;
    core_pkg::rob_alloc_t rob_alloc;
    core_pkg::uop_t       uop;
    core_pkg::wb_t        wb;
    core_pkg::free_ret_t  free_ret;

    fetch_stage #(
        .FETCH_DEPTH(FETCH_DEPTH)
    ) fetch_stage_i (
        .clk         (clk),
        .reset       (reset),
        .imem_data   (imem_data),
        .imem_ready  (imem_ready),
        .fetch_pop   (fetch_pop),
        .imem_addr   (imem_addr),
        .imem_req    (imem_req),
        .fetch_valid (fetch_valid),
        .fetch_pkt   (fetch_pkt)
    );

    rename_stage rename_stage_i (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_pkt   (fetch_pkt),
        .rob_full    (rob_full),
        .alloc_idx   (alloc_idx),
        .iq_full     (iq_full),
        .free_ret    (free_ret),
        .fetch_pop   (fetch_pop),
        .rob_alloc   (rob_alloc),
        .uop         (uop)
    );

    issue_stage #(
        .IQ_DEPTH(IQ_DEPTH)
    ) issue_stage_i (
        .clk     (clk),
        .reset   (reset),
        .uop     (uop),
        .iq_full (iq_full),
        .wb      (wb)
    );

    reorder_buffer reorder_buffer_i (
        .clk       (clk),
        .reset     (reset),
        .rob_alloc (rob_alloc),
        .wb        (wb),
        .rob_full  (rob_full),
        .alloc_idx (alloc_idx),
        .free_ret  (free_ret),
        .commit    (commit)
    );

endmodule

//--- test/core_tb.sv
// Testbench for the rename core running directed programs against an in-order reference model
`timescale 1ns/1ps

module core_tb;

    localparam int IMEM_WORDS     = 256;
    localparam int FETCH_DEPTH    = 8;
    localparam int IQ_DEPTH       = 8;
    localparam int TOTAL_INSTS    = 8 + 12 + 6 + 80 + 40 + 6;
    localparam int TIMEOUT_CYCLES = 10 * TOTAL_INSTS + 200;
    localparam logic [6:0] FUNCT7_ADD = 7'b0000000;

    logic              clk;
    logic              reset;
    core_pkg::inst_t   imem_data;
    logic              imem_ready;
    core_pkg::addr_t   imem_addr;
    logic              imem_req;
    core_pkg::commit_t commit;

    core_pkg::inst_t     imem [IMEM_WORDS];
    core_pkg::addr_t     exp_pc [IMEM_WORDS];
    core_pkg::arch_reg_t exp_rd [IMEM_WORDS];
    core_pkg::data_t     exp_val [IMEM_WORDS];

    int          mismatch_count = 0;
    int          missing_count = 0;
    int          req_error_count = 0;
    int          cycles = 0;
    logic        throttle;
    logic [31:0] lfsr = 32'h7c9e_a3d2;
    logic [1:0]  stretch = '0;

    rename_core #(
        .FETCH_DEPTH(FETCH_DEPTH),
        .IQ_DEPTH   (IQ_DEPTH)
    ) rename_core_i (
        .clk        (clk),
        .reset      (reset),
        .imem_data  (imem_data),
        .imem_ready (imem_ready),
        .imem_addr  (imem_addr),
        .imem_req   (imem_req),
        .commit     (commit)
    );

    // Word-addressed memory model, answers in the same cycle
    assign imem_data = imem[imem_addr[9:2]];

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        lfsr_step = state >> 1;
        if (state[0]) begin
            lfsr_step = lfsr_step ^ 32'h8020_0003;
        end
    endfunction

    // Ready level plus a hold of 0 to 3 extra cycles, one LFSR step per bit
    always @(posedge clk) begin
        if (!throttle) begin
            imem_ready <= 1'b1;
        end else if (stretch == 2'd0) begin
            imem_ready <= lfsr[0];
            lfsr = lfsr_step(lfsr);
            stretch[0] <= lfsr[0];
            lfsr = lfsr_step(lfsr);
            stretch[1] <= lfsr[0];
            lfsr = lfsr_step(lfsr);
        end else begin
            stretch <= stretch - 2'd1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors: %0d mismatches, %0d missing commits, %0d request errors",
                     mismatch_count, missing_count, req_error_count);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_data(input string test, input string field,
                              input core_pkg::data_t expected, input core_pkg::data_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_addr(input string test, input string field,
                              input core_pkg::addr_t expected, input core_pkg::addr_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_reg(input string test, input string field,
                             input core_pkg::arch_reg_t expected,
                             input core_pkg::arch_reg_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s %s: expected x%0d, actual x%0d", test, field, expected, actual);
            mismatch_count++;
        end
    endtask

    function automatic core_pkg::inst_t make_addi(input int rd, input int rs1, input int imm);
        make_addi = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], core_pkg::OPCODE_ARITH_I};
    endfunction

    function automatic core_pkg::inst_t make_reg_op(input logic [6:0] funct7, input int rd,
                                                    input int rs1, input int rs2);
        make_reg_op = {funct7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], core_pkg::OPCODE_ARITH_R};
    endfunction

    // Unused words keep opcode zero, upper bits follow the word address
    task automatic fill_imem();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = {i[24:0], 7'b0000000};
        end
    endtask

    // In-order execution of the loaded program on 32 registers
    task automatic build_expected(input int n);
        core_pkg::data_t     regs [32];
        core_pkg::inst_t     inst;
        core_pkg::data_t     a;
        core_pkg::data_t     b;
        core_pkg::data_t     imm;
        core_pkg::data_t     result;
        core_pkg::arch_reg_t rd;
        logic                writes;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int i = 0; i < n; i++) begin
            inst   = imem[i];
            rd     = inst[11:7];
            a      = regs[inst[19:15]];
            b      = regs[inst[24:20]];
            imm    = $signed(inst[31:20]);
            writes = 1'b1;
            result = '0;
            if (inst[6:0] == core_pkg::OPCODE_ARITH_I && inst[14:12] == 3'b000) begin
                result = a + imm;
            end else if (inst[6:0] == core_pkg::OPCODE_ARITH_R && inst[14:12] == 3'b000 &&
                         inst[31:25] == FUNCT7_ADD) begin
                result = a + b;
            end else if (inst[6:0] == core_pkg::OPCODE_ARITH_R && inst[14:12] == 3'b000 &&
                         inst[31:25] == core_pkg::FUNCT7_SUB) begin
                result = a - b;
            end else begin
                writes = 1'b0;
            end
            // No destination, or x0, commits as rd 0 with value 0
            if (!writes || rd == '0) begin
                rd     = '0;
                result = '0;
            end
            regs[rd]   = result;
            exp_pc[i]  = core_pkg::addr_t'(i * 4);
            exp_rd[i]  = rd;
            exp_val[i] = result;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    endtask

    // Fetch side follows the memory view, PC steps by 4 on each accepted word
    task automatic run_test(input string name, input int n);
        int got;
        int waited;
        int fetched;
        build_expected(n);
        apply_reset();
        got     = 0;
        waited  = 0;
        fetched = 0;
        while (got < n && waited < 10 * n + 16) begin
            @(negedge clk);
            waited++;
            if (commit.valid) begin
                check_addr(name, $sformatf("pc of commit %0d", got), exp_pc[got], commit.pc);
                check_reg(name, $sformatf("rd of commit %0d", got), exp_rd[got], commit.arch_rd);
                check_data(name, $sformatf("value of commit %0d", got), exp_val[got],
                           commit.value);
                got++;
            end
            // A full buffer only holds words that have not committed yet
            if (!imem_req && fetched - got < FETCH_DEPTH) begin
                $display("Test %s dropped imem_req with only %0d words outstanding",
                         name, fetched - got);
                req_error_count++;
            end
            check_addr(name, "fetch address", core_pkg::addr_t'(fetched * 4), imem_addr);
            if (imem_req && imem_ready) begin
                fetched++;
            end
        end
        if (got < n) begin
            $display("Test %s ended with %0d of %0d commits still missing", name, n - got, n);
            missing_count += n - got;
        end
    endtask

    // Alternating ADDI, ADD, SUB, each reading the two previous results
    task automatic load_mixed(input int n, input int nregs, input int imm_base,
                              input int imm_step);
        int rd;
        int rs1;
        int rs2;
        for (int i = 0; i < n; i++) begin
            rd  = 1 + i % nregs;
            rs1 = 1 + (i + 1) % nregs;
            rs2 = 1 + (i + 2) % nregs;
            case (i % 3)
                0:       imem[i] = make_addi(rd, rs1, imm_base + i * imm_step);
                1:       imem[i] = make_reg_op(FUNCT7_ADD, rd, rs1, rs2);
                default: imem[i] = make_reg_op(core_pkg::FUNCT7_SUB, rd, rs1, rs2);
            endcase
        end
    endtask

    task automatic test_addi_sequence();
        int imms [8] = '{5, -3, 2047, -2048, 100, -1, 0, 1234};
        throttle = 1'b0;
        fill_imem();
        for (int i = 0; i < 8; i++) begin
            imem[i] = make_addi(i + 1, 0, imms[i]);
        end
        run_test("addi_sequence", 8);
    endtask

    task automatic test_dependent_chains();
        throttle = 1'b0;
        fill_imem();
        imem[0]  = make_addi(1, 0, 7);
        imem[1]  = make_addi(2, 0, 3);
        imem[2]  = make_reg_op(FUNCT7_ADD, 3, 1, 2);
        imem[3]  = make_reg_op(FUNCT7_ADD, 3, 3, 3);
        imem[4]  = make_reg_op(core_pkg::FUNCT7_SUB, 4, 3, 1);
        imem[5]  = make_reg_op(core_pkg::FUNCT7_SUB, 4, 4, 2);
        imem[6]  = make_reg_op(FUNCT7_ADD, 5, 4, 3);
        imem[7]  = make_reg_op(core_pkg::FUNCT7_SUB, 5, 0, 5);
        imem[8]  = make_reg_op(FUNCT7_ADD, 6, 5, 5);
        imem[9]  = make_reg_op(core_pkg::FUNCT7_SUB, 6, 6, 1);
        imem[10] = make_reg_op(FUNCT7_ADD, 1, 6, 6);
        imem[11] = make_reg_op(core_pkg::FUNCT7_SUB, 2, 1, 2);
        run_test("dependent_chains", 12);
    endtask

    task automatic test_x0_register();
        throttle = 1'b0;
        fill_imem();
        imem[0] = make_addi(1, 0, 9);
        imem[1] = make_addi(0, 1, 77);
        imem[2] = make_reg_op(FUNCT7_ADD, 2, 0, 1);
        imem[3] = make_reg_op(core_pkg::FUNCT7_SUB, 3, 0, 1);
        imem[4] = make_reg_op(FUNCT7_ADD, 0, 2, 3);
        imem[5] = make_reg_op(core_pkg::FUNCT7_SUB, 4, 2, 0);
        run_test("x0_register", 6);
    endtask

    // 80 renames on three registers cycle the 32 spare registers
    task automatic test_free_list_recycling();
        throttle = 1'b0;
        fill_imem();
        load_mixed(80, 3, -400, 13);
        run_test("free_list_recycling", 80);
    endtask

    task automatic test_back_pressure();
        throttle = 1'b1;
        fill_imem();
        load_mixed(40, 7, 300, -17);
        run_test("back_pressure", 40);
    endtask

    task automatic test_other_opcodes();
        throttle = 1'b0;
        fill_imem();
        imem[0] = make_addi(1, 0, 11);
        imem[1] = make_addi(2, 0, 22);
        // rd fields point at x1 and x2, which must stay intact
        imem[2] = {12'h123, 5'd1, 3'b000, 5'd1, 7'b1110011};
        imem[3] = make_reg_op(FUNCT7_ADD, 3, 1, 2);
        imem[4] = {12'd4, 5'd0, 3'b010, 5'd2, 7'b0000011};
        imem[5] = make_reg_op(core_pkg::FUNCT7_SUB, 4, 2, 1);
        run_test("other_opcodes", 6);
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        imem_ready = 1'b1;
        throttle   = 1'b0;
        fill_imem();
        test_addi_sequence();
        test_dependent_chains();
        test_x0_register();
        test_free_list_recycling();
        test_back_pressure();
        test_other_opcodes();
        $display("Errors: %0d mismatches, %0d missing commits, %0d request errors",
                 mismatch_count, missing_count, req_error_count);
        if (mismatch_count + missing_count + req_error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- Bender.yml
package:
  name: rename_core

sources:
  - design/core_pkg.sv
  - design/fetch_stage.sv
  - design/rename_stage.sv
  - design/issue_stage.sv
  - design/reorder_buffer.sv
  - design/rename_core.sv
  - target: test
    files:
      - test/core_tb.sv

//--- filelist.f
design/core_pkg.sv
design/fetch_stage.sv
design/rename_stage.sv
design/issue_stage.sv
design/reorder_buffer.sv
design/rename_core.sv
test/core_tb.sv
